// ==== logic/pci_config_space.sv ====
`timescale 1ns/1ps
module pci_config_space
	import pci_target_pkg::*;
(
	input  logic        clk,
	input  logic        rst_i,
	input  pci_space_t  space_i,
	input  logic [5:0]  addr_i,
	input  logic [3:0]  be_i,
	input  logic        wr_i,
	input  logic [31:0] wdata_i,
	input  logic        parity_err_i,
	output logic [31:0] rdata_o,
	output logic [31:0] bar0_o,
	output logic [31:0] bar1_o,
	output logic        io_en_o,
	output logic        mem_en_o,
	output logic        perr_en_o
);
	logic [15:0] cmd_q;
	logic [15:0] status;
	logic [31:0] bar0_q;
	logic [31:0] bar1_q;
	logic        det_perr_q;
	logic        cfg_wr;
	logic        sts_clear;

	// replaces the enabled byte lanes of a register, keeping only writable bits.
	function automatic logic [31:0] merge_bytes(
		input logic [31:0] cur,
		input logic [31:0] wdata,
		input logic [3:0]  be,
		input logic [31:0] mask
	);
		logic [31:0] res;
		res = cur;
		for (int b = 0; b < 4; b++)
		begin
			if (be[b])
				res[8*b +: 8] = wdata[8*b +: 8] & mask[8*b +: 8];
		end
		return res;
	endfunction

	assign cfg_wr = wr_i && (space_i == space_cfg);
	assign sts_clear = cfg_wr && addr_i == REG_CMD_STS && be_i[(16 + STS_DET_PERR) / 8] &&
		wdata_i[16 + STS_DET_PERR];

	always_ff @(posedge clk)
	begin
		if (rst_i)
		begin
			cmd_q      <= '0;
			bar0_q     <= '0;
			bar1_q     <= '0;
			det_perr_q <= 1'b0;
		end
		else
		begin
			if (cfg_wr && addr_i == REG_CMD_STS)
			begin
				if (be_i[0])
					cmd_q[7:0] <= wdata_i[7:0] & CMD_WR_MASK[7:0];
				if (be_i[1])
					cmd_q[15:8] <= wdata_i[15:8] & CMD_WR_MASK[15:8];
			end
			if (cfg_wr && addr_i == REG_BAR0)
				bar0_q <= merge_bytes(bar0_q, wdata_i, be_i, BAR0_MASK);
			if (cfg_wr && addr_i == REG_BAR1)
				bar1_q <= merge_bytes(bar1_q, wdata_i, be_i, BAR1_MASK);
			if (parity_err_i)
				det_perr_q <= 1'b1; // a new error wins over a clear in the same cycle.
			else if (sts_clear)
				det_perr_q <= 1'b0;
		end
	end

	always_comb
	begin
		status = '0;
		status[STS_DET_PERR] = det_perr_q;
	end

	assign bar0_o = bar0_q;
	assign bar1_o = bar1_q | 32'h1; // bit 0 marks I/O space.

	always_comb
	begin
		case (addr_i)
			REG_ID:      rdata_o = {DEVICE_ID, VENDOR_ID};
			REG_CMD_STS: rdata_o = {status, cmd_q};
			REG_BAR0:    rdata_o = bar0_o;
			REG_BAR1:    rdata_o = bar1_o;
			default:     rdata_o = '0;
		endcase
	end

	assign io_en_o   = cmd_q[CMD_IO_EN];
	assign mem_en_o  = cmd_q[CMD_MEM_EN];
	assign perr_en_o = cmd_q[CMD_PERR_EN];

	a_bar_reserved: assert property (@(posedge clk) disable iff (rst_i)
		((bar0_o & ~BAR0_MASK) == '0) && ((bar1_o & ~BAR1_MASK) == 32'h1));

endmodule

// ==== logic/pci_parity.sv ====
`timescale 1ns/1ps
module pci_parity
(
	input  logic        clk,
	input  logic        rst_i,
	input  logic [31:0] ad_i,
	input  logic [3:0]  cbe_i,
	input  logic        par_i,
	input  logic        ad_oe_i,
	input  logic        frame_n_i,
	input  logic        irdy_n_i,
	input  logic        trdy_n_i,
	input  logic        perr_en_i,
	output logic        par_o,
	output logic        par_oe_o,
	output logic        perr_n_o,
	output logic        perr_oe_o,
	output logic        parity_err_o
);
	logic calc_q;
	logic addr_chk_q;
	logic data_chk_q;
	logic perr_low_q;
	logic perr_high_q;
	logic wr_data_phase;
	logic addr_err;
	logic data_err;

	// a completed data phase that the target did not drive is a write.
	assign wr_data_phase = !irdy_n_i && !trdy_n_i && !ad_oe_i;

	// PAR always trails AD and CBE by one clock.
	assign addr_err = addr_chk_q && (par_i != calc_q);
	assign data_err = data_chk_q && (par_i != calc_q);

	always_ff @(posedge clk)
		calc_q <= ^{ad_i, cbe_i};

	always_ff @(posedge clk)
	begin
		if (rst_i)
		begin
			addr_chk_q   <= 1'b0;
			data_chk_q   <= 1'b0;
			par_oe_o     <= 1'b0;
			perr_low_q   <= 1'b0;
			perr_high_q  <= 1'b0;
			parity_err_o <= 1'b0;
		end
		else
		begin
			addr_chk_q   <= !frame_n_i && irdy_n_i;
			data_chk_q   <= wr_data_phase;
			par_oe_o     <= ad_oe_i;
			perr_low_q   <= data_err && perr_en_i;
			perr_high_q  <= perr_low_q; // one cycle high before release.
			parity_err_o <= addr_err || data_err;
		end
	end

	assign par_o     = calc_q;
	assign perr_n_o  = !perr_low_q;
	assign perr_oe_o = perr_low_q || perr_high_q;

	a_perr_after_write: assert property (@(posedge clk) disable iff (rst_i)
		(perr_oe_o && !perr_n_o) |-> $past(wr_data_phase, 2));

endmodule

// ==== logic/pci_target_fsm.sv ====
`timescale 1ns/1ps
module pci_target_fsm
	import pci_target_pkg::*;
(
	input  logic        clk,
	input  logic        rst_i,
	input  logic        frame_n_i,
	input  logic        irdy_n_i,
	input  logic        idsel_i,
	input  logic [31:0] ad_i,
	input  logic [3:0]  cbe_i,
	input  logic [31:0] bar0_i,
	input  logic [31:0] bar1_i,
	input  logic        io_en_i,
	input  logic        mem_en_i,
	input  logic [31:0] cfg_rdata_i,
	input  logic [31:0] mem_rdata_i,
	input  logic [31:0] io_rdata_i,
	output logic        devsel_n_o,
	output logic        trdy_n_o,
	output logic        ctl_oe_o,
	output logic [31:0] ad_o,
	output logic        ad_oe_o,
	output pci_space_t  space_o,
	output logic [5:0]  addr_o,
	output logic [3:0]  be_o,
	output logic        wr_o
);
	typedef enum logic [1:0] {st_idle, st_decode, st_data, st_turn} state_t;

	state_t     state_q;
	pci_cmd_t   cmd_q;
	pci_space_t space_q;
	pci_space_t hit_space;
	logic [5:0]  addr_q;
	logic [31:0] rdata;
	logic        addr_phase;
	logic        is_write;
	logic        bar0_hit;
	logic        bar1_hit;

	assign addr_phase = !frame_n_i && irdy_n_i;
	assign bar0_hit = ((ad_i ^ bar0_i) & BAR0_MASK) == '0;
	assign bar1_hit = ((ad_i ^ bar1_i) & BAR1_MASK) == '0;

	// address decode, valid only while the address phase is on the bus.
	always_comb
	begin
		hit_space = space_none;
		case (cbe_i)
			cmd_conf_read, cmd_conf_write:
				if (idsel_i && ad_i[1:0] == 2'b00)
					hit_space = space_cfg;
			cmd_mem_read, cmd_mem_write:
				if (mem_en_i && bar0_hit)
					hit_space = space_mem;
			cmd_io_read, cmd_io_write:
				if (io_en_i && bar1_hit)
					hit_space = space_io;
			default:
				hit_space = space_none;
		endcase
	end

	assign is_write = (cmd_q == cmd_io_write) || (cmd_q == cmd_mem_write) ||
		(cmd_q == cmd_conf_write);

	always_comb
	begin
		case (space_q)
			space_cfg: rdata = cfg_rdata_i;
			space_mem: rdata = mem_rdata_i;
			space_io:  rdata = io_rdata_i;
			default:   rdata = '0;
		endcase
	end

	always_ff @(posedge clk)
	begin
		if (rst_i)
		begin
			state_q    <= st_idle;
			space_q    <= space_none;
			devsel_n_o <= 1'b1;
			trdy_n_o   <= 1'b1;
			ctl_oe_o   <= 1'b0;
			ad_oe_o    <= 1'b0;
		end
		else
		begin
			case (state_q)
				st_idle:
					if (addr_phase && hit_space != space_none)
					begin
						space_q <= hit_space;
						state_q <= st_decode;
					end
				st_decode:
				begin
					devsel_n_o <= 1'b0;
					trdy_n_o   <= 1'b0;
					ctl_oe_o   <= 1'b1;
					ad_oe_o    <= !is_write; // AD turns around only for reads.
					state_q    <= st_data;
				end
				st_data:
					if (!irdy_n_i)
					begin
						devsel_n_o <= 1'b1;
						trdy_n_o   <= 1'b1;
						ad_oe_o    <= 1'b0;
						state_q    <= st_turn;
					end
				default:
				begin
					ctl_oe_o <= 1'b0; // lines were high for a cycle, now released.
					space_q  <= space_none;
					state_q  <= st_idle;
				end
			endcase
		end
	end

	always_ff @(posedge clk)
	begin
		if (state_q == st_idle && addr_phase)
		begin
			cmd_q  <= pci_cmd_t'(cbe_i);
			addr_q <= ad_i[7:2];
		end
		if (state_q == st_decode)
			ad_o <= rdata; // read word is on AD from edge N+1.
	end

	assign space_o = space_q;
	assign addr_o  = addr_q;
	assign be_o    = ~cbe_i;
	assign wr_o    = (state_q == st_data) && !irdy_n_i && is_write;

	a_trdy_needs_devsel: assert property (@(posedge clk) disable iff (rst_i)
		(ctl_oe_o && !trdy_n_o) |-> !devsel_n_o);

	a_wr_single: assert property (@(posedge clk) disable iff (rst_i)
		wr_o |=> !wr_o);

endmodule

// ==== logic/pci_target_mem.sv ====
`timescale 1ns/1ps
module pci_target_mem
#(
	parameter int DEPTH = 64
)
(
	input  logic                     clk,
	input  logic                     we_i,
	input  logic [$clog2(DEPTH)-1:0] addr_i,
	input  logic [3:0]               be_i,
	input  logic [31:0]              wdata_i,
	output logic [31:0]              rdata_o
);
	logic [31:0] mem [DEPTH];

	// each enabled byte lane is written on its own.
	always_ff @(posedge clk)
	begin
		if (we_i)
		begin
			for (int b = 0; b < 4; b++)
			begin
				if (be_i[b])
					mem[addr_i][8*b +: 8] <= wdata_i[8*b +: 8];
			end
		end
	end

	assign rdata_o = mem[addr_i]; // the fsm registers this word before the data phase.

endmodule

// ==== logic/pci_target_pkg.sv ====
package pci_target_pkg;

	// bus commands decoded by the target.
	typedef enum logic [3:0]
	{
		cmd_io_read    = 4'h2,
		cmd_io_write   = 4'h3,
		cmd_mem_read   = 4'h6,
		cmd_mem_write  = 4'h7,
		cmd_conf_read  = 4'hA,
		cmd_conf_write = 4'hB
	} pci_cmd_t;

	// which register set an access lands in.
	typedef enum logic [1:0]
	{
		space_none,
		space_cfg,
		space_mem,
		space_io
	} pci_space_t;

	localparam logic [15:0] VENDOR_ID = 16'h1e4f;
	localparam logic [15:0] DEVICE_ID = 16'h7a21;

	localparam int MEM_WORDS = 64; // 256 bytes behind BAR0.
	localparam int IO_WORDS  = 4;  // 16 bytes behind BAR1.

	localparam logic [31:0] BAR0_MASK = 32'hffff_ff00;
	localparam logic [31:0] BAR1_MASK = 32'hffff_fff0;

	// configuration register numbers, as dword index AD[7:2].
	localparam logic [5:0] REG_ID      = 6'd0;
	localparam logic [5:0] REG_CMD_STS = 6'd1;
	localparam logic [5:0] REG_BAR0    = 6'd4;
	localparam logic [5:0] REG_BAR1    = 6'd5;

	localparam int CMD_IO_EN   = 0;
	localparam int CMD_MEM_EN  = 1;
	localparam int CMD_PERR_EN = 6;

	// only the three enables are implemented in the command register.
	localparam logic [15:0] CMD_WR_MASK =
		(16'h1 << CMD_IO_EN) | (16'h1 << CMD_MEM_EN) | (16'h1 << CMD_PERR_EN);

	localparam int STS_DET_PERR = 15; // position in the upper half of register 1.

endpackage

// ==== logic/pci_target_top.sv ====
`timescale 1ns/1ps
module pci_target_top
	import pci_target_pkg::*;
(
	input  logic        clk,
	input  logic        rst_i,
	inout  wire  [31:0] ad_io,
	input  logic [3:0]  cbe_i,
	inout  wire         par_io,
	input  logic        frame_n_i,
	input  logic        irdy_n_i,
	inout  wire         trdy_n_io,
	inout  wire         devsel_n_io,
	inout  wire         perr_n_io,
	input  logic        idsel_i
);
	logic        devsel_n;
	logic        trdy_n;
	logic        ctl_oe;
	logic [31:0] ad_out;
	logic        ad_oe;
	pci_space_t  space;
	logic [5:0]  addr;
	logic [3:0]  be;
	logic        wr;
	logic [31:0] cfg_rdata;
	logic [31:0] mem_rdata;
	logic [31:0] io_rdata;
	logic [31:0] bar0;
	logic [31:0] bar1;
	logic        io_en;
	logic        mem_en;
	logic        perr_en;
	logic        par;
	logic        par_oe;
	logic        perr_n;
	logic        perr_oe;
	logic        parity_err;
	logic        mem_we;
	logic        io_we;

	assign mem_we = wr && (space == space_mem);
	assign io_we  = wr && (space == space_io);

	pci_target_fsm u_fsm (
		.clk(clk), .rst_i(rst_i), .frame_n_i(frame_n_i), .irdy_n_i(irdy_n_i),
		.idsel_i(idsel_i), .ad_i(ad_io), .cbe_i(cbe_i), .bar0_i(bar0), .bar1_i(bar1),
		.io_en_i(io_en), .mem_en_i(mem_en), .cfg_rdata_i(cfg_rdata),
		.mem_rdata_i(mem_rdata), .io_rdata_i(io_rdata), .devsel_n_o(devsel_n),
		.trdy_n_o(trdy_n), .ctl_oe_o(ctl_oe), .ad_o(ad_out), .ad_oe_o(ad_oe),
		.space_o(space), .addr_o(addr), .be_o(be), .wr_o(wr)
	);

	pci_config_space u_cfg (
		.clk(clk), .rst_i(rst_i), .space_i(space), .addr_i(addr), .be_i(be), .wr_i(wr),
		.wdata_i(ad_io), .parity_err_i(parity_err), .rdata_o(cfg_rdata), .bar0_o(bar0),
		.bar1_o(bar1), .io_en_o(io_en), .mem_en_o(mem_en), .perr_en_o(perr_en)
	);

	pci_target_mem #(.DEPTH(MEM_WORDS)) u_mem (
		.clk(clk), .we_i(mem_we), .addr_i(addr[$clog2(MEM_WORDS)-1:0]), .be_i(be),
		.wdata_i(ad_io), .rdata_o(mem_rdata)
	);

	// the I/O window decodes only the low word index bits.
	pci_target_mem #(.DEPTH(IO_WORDS)) u_io (
		.clk(clk), .we_i(io_we), .addr_i(addr[$clog2(IO_WORDS)-1:0]), .be_i(be),
		.wdata_i(ad_io), .rdata_o(io_rdata)
	);

	pci_parity u_parity (
		.clk(clk), .rst_i(rst_i), .ad_i(ad_io), .cbe_i(cbe_i), .par_i(par_io),
		.ad_oe_i(ad_oe), .frame_n_i(frame_n_i), .irdy_n_i(irdy_n_i),
		.trdy_n_i(trdy_n_io), .perr_en_i(perr_en), .par_o(par), .par_oe_o(par_oe),
		.perr_n_o(perr_n), .perr_oe_o(perr_oe), .parity_err_o(parity_err)
	);

	assign ad_io       = ad_oe ? ad_out : 'z;
	assign par_io      = par_oe ? par : 1'bz;
	assign trdy_n_io   = ctl_oe ? trdy_n : 1'bz;
	assign devsel_n_io = ctl_oe ? devsel_n : 1'bz;
	assign perr_n_io   = perr_oe ? perr_n : 1'bz;

endmodule

// ==== tb.f ====
logic/pci_target_pkg.sv
logic/pci_target_fsm.sv
logic/pci_config_space.sv
logic/pci_target_mem.sv
logic/pci_parity.sv
logic/pci_target_top.sv
verification/tb_clock_gen.sv
verification/pci_master_model.sv
verification/tb_pci_target.sv

// ==== verification/pci_master_model.sv ====
`timescale 1ns/1ps
module pci_master_model
	import pci_target_pkg::*;
(
	input  logic        clk,
	inout  wire  [31:0] ad_io,
	output logic [3:0]  cbe_o,
	inout  wire         par_io,
	output logic        frame_n_o,
	output logic        irdy_n_o,
	input  logic        trdy_n_i,
	input  logic        devsel_n_i,
	output logic        idsel_o,
	output logic        rd_active_o
);
	logic [31:0] ad_drv;
	logic        ad_oe;
	logic        par_drv;
	logic        par_oe;
	logic        bad_parity; // inverts PAR of the next write data phase.

	assign ad_io  = ad_oe ? ad_drv : 'z;
	assign par_io = par_oe ? par_drv : 1'bz;

	initial
	begin
		frame_n_o   = 1'b1;
		irdy_n_o    = 1'b1;
		cbe_o       = 4'h0;
		idsel_o     = 1'b0;
		rd_active_o = 1'b0;
		ad_drv      = '0;
		ad_oe       = 1'b0;
		par_drv     = 1'b0;
		par_oe      = 1'b0;
		bad_parity  = 1'b0;
	end

	// one single-data-phase transaction, all driving on falling edges.
	task automatic bus_cycle(input pci_cmd_t cmd, input logic [31:0] addr, input logic sel,
		input logic [31:0] wdata, input logic [3:0] be,
		output logic [31:0] rdata, output logic abort);
		logic is_read;
		int   waits;
		is_read = (cmd == cmd_io_read) || (cmd == cmd_mem_read) || (cmd == cmd_conf_read);
		rdata = '1;
		waits = 0;
		@(negedge clk);
		frame_n_o   = 1'b0;
		irdy_n_o    = 1'b1;
		idsel_o     = sel;
		cbe_o       = cmd;
		ad_drv      = addr;
		ad_oe       = 1'b1;
		rd_active_o = is_read;
		@(negedge clk);
		frame_n_o = 1'b1; // last data phase.
		irdy_n_o  = 1'b0;
		idsel_o   = 1'b0;
		par_drv   = ^{addr, cmd};
		par_oe    = 1'b1;
		cbe_o     = ~be;
		ad_drv    = wdata;
		ad_oe     = !is_read;
		do
		begin
			@(negedge clk);
			par_oe = 1'b0;
			waits++;
		end
		while ((devsel_n_i !== 1'b0 || trdy_n_i !== 1'b0) && waits < 5);
		abort = (devsel_n_i !== 1'b0 || trdy_n_i !== 1'b0);
		if (!abort)
		begin
			if (is_read)
				rdata = ad_io;
			@(negedge clk);
			par_drv = ^{wdata, ~be} ^ bad_parity;
			par_oe  = !is_read;
		end
		irdy_n_o    = 1'b1;
		ad_oe       = 1'b0;
		cbe_o       = 4'h0;
		rd_active_o = 1'b0;
		if (!is_read)
			bad_parity = 1'b0;
		@(negedge clk);
		par_oe = 1'b0;
	endtask

	task automatic config_write(input logic [5:0] idx, input logic [31:0] data,
		input logic [3:0] be, output logic abort);
		logic [31:0] unused;
		bus_cycle(cmd_conf_write, {24'h0, idx, 2'b00}, 1'b1, data, be, unused, abort);
	endtask

	task automatic config_read(input logic [5:0] idx, output logic [31:0] data,
		output logic abort);
		bus_cycle(cmd_conf_read, {24'h0, idx, 2'b00}, 1'b1, '0, 4'hf, data, abort);
	endtask

	task automatic memory_write(input logic [31:0] addr, input logic [31:0] data,
		input logic [3:0] be, output logic abort);
		logic [31:0] unused;
		bus_cycle(cmd_mem_write, addr, 1'b0, data, be, unused, abort);
	endtask

	task automatic memory_read(input logic [31:0] addr, output logic [31:0] data,
		output logic abort);
		bus_cycle(cmd_mem_read, addr, 1'b0, '0, 4'hf, data, abort);
	endtask

	task automatic io_write(input logic [31:0] addr, input logic [31:0] data,
		input logic [3:0] be, output logic abort);
		logic [31:0] unused;
		bus_cycle(cmd_io_write, addr, 1'b0, data, be, unused, abort);
	endtask

	task automatic io_read(input logic [31:0] addr, output logic [31:0] data,
		output logic abort);
		bus_cycle(cmd_io_read, addr, 1'b0, '0, 4'hf, data, abort);
	endtask

endmodule

// ==== verification/tb_clock_gen.sv ====
`timescale 1ns/1ps
module tb_clock_gen
(
	output logic clk,
	output logic rst_o
);
	initial
	begin
		clk = 1'b0;
		forever #20 clk = ~clk; // 40 ns period.
	end

	initial
	begin
		rst_o = 1'b1;
		repeat (4) @(posedge clk);
		@(negedge clk);
		rst_o = 1'b0;
	end

endmodule

// ==== verification/tb_pci_target.sv ====
`timescale 1ns/1ps
module tb_pci_target
	import pci_target_pkg::*;
;
	localparam int TIMEOUT_CYCLES = 3000; // about 150 transactions of up to 8 cycles, plus margin.

	wire        clk;
	wire        rst;
	wire [31:0] ad;
	wire [3:0]  cbe;
	wire        par;
	wire        frame_n;
	wire        irdy_n;
	wire        trdy_n;
	wire        devsel_n;
	wire        perr_n;
	wire        idsel;
	wire        rd_active;

	pullup (frame_n);
	pullup (irdy_n);
	pullup (trdy_n);
	pullup (devsel_n);
	pullup (perr_n);
	pullup (par);

	logic [31:0] ref_mem [MEM_WORDS];
	logic [31:0] ref_io [IO_WORDS];
	logic [31:0] ref_bar0;
	logic [31:0] ref_bar1;
	logic [15:0] ref_cmd;
	logic [31:0] rdata;
	logic [31:0] wdata;
	logic [31:0] rnd;
	logic [31:0] addr;
	logic [3:0]  be;
	logic        abort;
	logic        expect_perr;
	integer      seed;
	int          cycles;

	tb_clock_gen u_clock (.clk(clk), .rst_o(rst));

	pci_target_top dut (
		.clk(clk), .rst_i(rst), .ad_io(ad), .cbe_i(cbe), .par_io(par), .frame_n_i(frame_n),
		.irdy_n_i(irdy_n), .trdy_n_io(trdy_n), .devsel_n_io(devsel_n), .perr_n_io(perr_n),
		.idsel_i(idsel)
	);

	pci_master_model master (
		.clk(clk), .ad_io(ad), .cbe_o(cbe), .par_io(par), .frame_n_o(frame_n),
		.irdy_n_o(irdy_n), .trdy_n_i(trdy_n), .devsel_n_i(devsel_n), .idsel_o(idsel),
		.rd_active_o(rd_active)
	);

	task automatic stop_on_error(input string why);
		$display("%s", why);
		$display("*** FAILED ***");
		$fatal(1);
	endtask

	task automatic check_word(input string name, input logic [31:0] got, input logic [31:0] exp);
		assert (got === exp)
		else
			stop_on_error($sformatf("mismatch %s got %h expected %h", name, got, exp));
	endtask

	task automatic check_abort(input string what, input logic got, input logic exp);
		assert (got === exp)
		else
			stop_on_error($sformatf("%s: master abort was %0d, expected %0d", what, got, exp));
	endtask

	task automatic cfg_expect(input logic [5:0] idx, input logic [31:0] exp);
		master.config_read(idx, rdata, abort);
		check_abort("config read", abort, 1'b0);
		check_word($sformatf("cfg_reg%0d", idx), rdata, exp);
	endtask

	// byte lanes with a set enable take the new data.
	function automatic logic [31:0] apply_lanes(input logic [31:0] cur, input logic [31:0] data,
		input logic [3:0] lanes);
		logic [31:0] res;
		res = cur;
		for (int i = 0; i < 4; i++)
			if (lanes[i])
				res[8*i +: 8] = data[8*i +: 8];
		return res;
	endfunction

	always @(posedge clk)
	begin
		cycles++;
		if (cycles >= TIMEOUT_CYCLES)
			stop_on_error("timeout: the test sequence did not finish within the cycle limit");
	end

	a_devsel_start: assert property (@(posedge clk) disable iff (rst)
		$fell(devsel_n) |-> ($past(frame_n, 2) == 1'b0) && (trdy_n == 1'b0))
	else
		stop_on_error("DEVSEL_N or TRDY_N did not go low right after edge N+1");

	a_devsel_release: assert property (@(posedge clk) disable iff (rst)
		$fell(devsel_n) |=> (devsel_n && trdy_n && dut.ctl_oe) ##1
			(devsel_n && trdy_n && !dut.ctl_oe))
	else
		stop_on_error("DEVSEL_N and TRDY_N were not driven high and then released");

	a_read_par: assert property (@(posedge clk) disable iff (rst)
		(!irdy_n && !trdy_n && rd_active) |=> (par == $past(^{ad, cbe})))
	else
		stop_on_error("read PAR does not match the parity of AD and CBE one cycle before");

	a_perr_low: assert property (@(posedge clk) disable iff (rst)
		(!irdy_n && !trdy_n && expect_perr) |-> ##2 (perr_n == 1'b0))
	else
		stop_on_error("PERR_N was not asserted after a bad write data phase");

	a_perr_only_expected: assert property (@(posedge clk) disable iff (rst)
		(perr_n == 1'b0) |-> expect_perr)
	else
		stop_on_error("PERR_N was asserted when no parity error was reported");

	initial
	begin
		seed = 32'hf6a6a1d3;
		cycles = 0;
		expect_perr = 1'b0;
		@(negedge rst);

		cfg_expect(REG_ID, {DEVICE_ID, VENDOR_ID});
		cfg_expect(REG_CMD_STS, 32'h0);
		cfg_expect(6'd2, 32'h0);
		cfg_expect(6'd9, 32'h0);
		master.memory_read(32'h0, rdata, abort);
		check_abort("memory read before enable", abort, 1'b1);

		master.config_write(REG_BAR0, 32'hffff_ffff, 4'hf, abort);
		ref_bar0 = BAR0_MASK;
		cfg_expect(REG_BAR0, ref_bar0);
		master.config_write(REG_BAR1, 32'hffff_ffff, 4'hf, abort);
		ref_bar1 = BAR1_MASK;
		cfg_expect(REG_BAR1, ref_bar1 | 32'h1);
		wdata = $random(seed);
		master.config_write(REG_BAR0, wdata, 4'b1010, abort);
		ref_bar0 = apply_lanes(ref_bar0, wdata, 4'b1010) & BAR0_MASK;
		cfg_expect(REG_BAR0, ref_bar0);
		wdata = $random(seed);
		master.config_write(REG_BAR1, wdata, 4'b0101, abort);
		ref_bar1 = apply_lanes(ref_bar1, wdata, 4'b0101) & BAR1_MASK;
		cfg_expect(REG_BAR1, ref_bar1 | 32'h1);
		wdata = $random(seed);
		master.config_write(REG_BAR0, wdata, 4'hf, abort);
		ref_bar0 = wdata & BAR0_MASK;
		cfg_expect(REG_BAR0, ref_bar0);
		wdata = $random(seed);
		master.config_write(REG_BAR1, wdata, 4'hf, abort);
		ref_bar1 = wdata & BAR1_MASK;
		cfg_expect(REG_BAR1, ref_bar1 | 32'h1);
		master.config_write(REG_CMD_STS, 32'h0000_ffff, 4'b0010, abort);
		ref_cmd = 16'h0; // no writable bits in the upper command byte.
		cfg_expect(REG_CMD_STS, {16'h0, ref_cmd});
		master.config_write(REG_CMD_STS, 32'h0000_00ff, 4'b0001, abort);
		ref_cmd = 16'h0043; // only the i/o, memory and parity error enables stick.
		cfg_expect(REG_CMD_STS, {16'h0, ref_cmd});

		// fill both windows so that every later read has a known value.
		for (int i = 0; i < MEM_WORDS; i++)
		begin
			ref_mem[i] = $random(seed);
			master.memory_write(ref_bar0 + 4 * i, ref_mem[i], 4'hf, abort);
			check_abort("memory fill", abort, 1'b0);
		end
		for (int i = 0; i < IO_WORDS; i++)
		begin
			ref_io[i] = $random(seed);
			master.io_write(ref_bar1 + 4 * i, ref_io[i], 4'hf, abort);
			check_abort("i/o fill", abort, 1'b0);
		end

		for (int i = 0; i < 40; i++)
		begin
			rnd = $random(seed);
			wdata = $random(seed);
			be = rnd[11:8];
			if (rnd[12])
			begin
				addr = ref_bar1 + 4 * rnd[1:0];
				if (rnd[13])
				begin
					master.io_write(addr, wdata, be, abort);
					ref_io[rnd[1:0]] = apply_lanes(ref_io[rnd[1:0]], wdata, be);
				end
				else
				begin
					master.io_read(addr, rdata, abort);
					check_word("io_rdata", rdata, ref_io[rnd[1:0]]);
				end
				check_abort("i/o access in window", abort, 1'b0);
			end
			else
			begin
				addr = ref_bar0 + 4 * rnd[5:0];
				if (rnd[13])
				begin
					master.memory_write(addr, wdata, be, abort);
					ref_mem[rnd[5:0]] = apply_lanes(ref_mem[rnd[5:0]], wdata, be);
				end
				else
				begin
					master.memory_read(addr, rdata, abort);
					check_word("mem_rdata", rdata, ref_mem[rnd[5:0]]);
				end
				check_abort("memory access in window", abort, 1'b0);
			end
		end

		master.memory_read(ref_bar0 + 32'd256, rdata, abort);
		check_abort("memory read above window", abort, 1'b1);
		master.io_read(ref_bar1 + 32'd16, rdata, abort);
		check_abort("i/o read above window", abort, 1'b1);

		// parity error with PERR_N reporting enabled.
		wdata = $random(seed);
		expect_perr = 1'b1;
		master.bad_parity = 1'b1;
		master.memory_write(ref_bar0, wdata, 4'hf, abort);
		ref_mem[0] = wdata;
		repeat (4) @(negedge clk);
		expect_perr = 1'b0;
		cfg_expect(REG_CMD_STS, (32'h1 << (16 + STS_DET_PERR)) | ref_cmd);
		master.config_write(REG_CMD_STS, (32'h1 << (16 + STS_DET_PERR)) | ref_cmd, 4'hf, abort);
		cfg_expect(REG_CMD_STS, {16'h0, ref_cmd});

		// same error with reporting disabled sets only the status bit.
		ref_cmd = 16'h0003;
		master.config_write(REG_CMD_STS, {16'h0, ref_cmd}, 4'hf, abort);
		wdata = $random(seed);
		master.bad_parity = 1'b1;
		master.memory_write(ref_bar0 + 4, wdata, 4'hf, abort);
		ref_mem[1] = wdata;
		repeat (4) @(negedge clk);
		cfg_expect(REG_CMD_STS, (32'h1 << (16 + STS_DET_PERR)) | ref_cmd);
		master.config_write(REG_CMD_STS, (32'h1 << (16 + STS_DET_PERR)) | ref_cmd, 4'hf, abort);
		cfg_expect(REG_CMD_STS, {16'h0, ref_cmd});
		master.memory_read(ref_bar0 + 4, rdata, abort);
		check_word("mem_rdata", rdata, ref_mem[1]);

		master.config_write(REG_CMD_STS, 32'h0, 4'hf, abort);
		master.memory_read(ref_bar0, rdata, abort);
		check_abort("memory read after disable", abort, 1'b1);
		master.io_read(ref_bar1, rdata, abort);
		check_abort("i/o read after disable", abort, 1'b1);

		$display("*** PASSED ***");
		$finish;
	end

endmodule
